// ==== flist.f ====
logic/isaPkg.sv
logic/ucodePkg.sv
logic/opcodeMap.sv
logic/ucodeRom.sv
logic/ucodeSequencer.sv
logic/dataPath.sv
logic/gbCore.sv
verif/programMemory.sv
verif/gbCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the micro-coded core

TOP       ?= gbCoreTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/gbCoreTb.sv ====
`default_nettype none
`timescale 1ns/100ps

module gbCoreTb;
	import isaPkg::*;

	localparam int ClockPeriod = 100;
	localparam logic [AddrWidth-1:0] StartPc = 16'h0100;
	localparam int AluIters = 12;
	localparam int InstrCount = 8 + 24 + 3 * AluIters + 4 + 9 + 10;
	// Two fetches, long stalls and the slowest response
	localparam int CycleBudget = 120;
	localparam int TimeoutCycles = 16 + InstrCount * CycleBudget;

	logic clock;
	logic rst;
	logic heavyStall;
	logic fetchReqValid;
	logic fetchReqReady;
	fetchReqT fetchReq;
	logic fetchRspValid;
	logic [WordWidth-1:0] fetchRsp;
	logic retireValid;
	retireT retire;

	// Reference model indexed by register code
	logic [WordWidth-1:0] modelReg [0:7];
	flagsT modelFlags;
	logic [AddrWidth-1:0] modelPc;
	integer seed;
	int errorCount;
	int checkCount;
	int testsRun;
	int testsFailed;

	gbCore #(.ResetPc(StartPc)) gbCore_inst
	(
		.clock(clock),
		.rst(rst),
		.fetchReqValid(fetchReqValid),
		.fetchReqReady(fetchReqReady),
		.fetchReq(fetchReq),
		.fetchRspValid(fetchRspValid),
		.fetchRsp(fetchRsp),
		.retireValid(retireValid),
		.retire(retire)
	);

	programMemory programMemory_inst
	(
		.clock(clock),
		.rst(rst),
		.heavyStall(heavyStall),
		.fetchReqValid(fetchReqValid),
		.fetchReqReady(fetchReqReady),
		.fetchReq(fetchReq),
		.fetchRspValid(fetchRspValid),
		.fetchRsp(fetchRsp)
	);

	always #(ClockPeriod / 2) clock = ~clock;

	////////////////////
	// Compare tasks
	////////////////////
	task automatic reportMismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errorCount++;
	endtask

	task automatic compareRetire(input retireT got, input retireT exp);
		checkCount++;
		if (got.opcode !== exp.opcode)
			reportMismatch("retire.opcode", 64'(got.opcode), 64'(exp.opcode));
		if (got.regs !== exp.regs)
			reportMismatch("retire.regs", 64'(got.regs), 64'(exp.regs));
		if (got.reserved !== exp.reserved)
			reportMismatch("retire.reserved", 64'(got.reserved), 64'(exp.reserved));
	endtask

	task automatic verifyFlags(input flagsT got, input flagsT exp);
		checkCount++;
		if (got !== exp)
			reportMismatch("retire.flags", 64'(got), 64'(exp));
	endtask

	task automatic checkPc(input logic [AddrWidth-1:0] got, input logic [AddrWidth-1:0] exp);
		checkCount++;
		if (got !== exp)
			reportMismatch("retire.pc", 64'(got), 64'(exp));
	endtask

	////////////////////
	// Instruction drivers
	////////////////////
	// Caller updates registers and flags of the model first
	task automatic runInstr(input logic [7:0] op, input logic [7:0] imm, input bit twoBytes,
		input int pcDelta);
		retireT got;
		retireT exp;
		programMemory_inst.mem[modelPc] = op;
		if (twoBytes)
			programMemory_inst.mem[modelPc + 16'd1] = imm;
		modelPc = modelPc + (twoBytes ? 16'd2 : 16'd1) + 16'(pcDelta);
		exp = '{opcode: op, pc: modelPc,
			regs: '{b: modelReg[0], c: modelReg[1], d: modelReg[2], e: modelReg[3],
				h: modelReg[4], l: modelReg[5], a: modelReg[7]},
			flags: modelFlags, reserved: '0};
		do
			@(negedge clock);
		while (!retireValid);
		got = retire;
		compareRetire(got, exp);
		verifyFlags(got.flags, exp.flags);
		checkPc(got.pc, exp.pc);
	endtask

	task automatic loadReg(input logic [2:0] r, input logic [7:0] value);
		modelReg[r] = value;
		runInstr({2'b00, r, 3'b110}, value, 1'b1, 0);
	endtask

	// INC or DEC leaves carry untouched
	task automatic stepReg(input logic [2:0] r, input bit dec);
		modelReg[r] = dec ? modelReg[r] - 8'd1 : modelReg[r] + 8'd1;
		modelFlags.zero = (modelReg[r] == 8'd0);
		modelFlags.subtract = dec;
		runInstr({2'b00, r, 2'b10, dec}, 8'h00, 1'b0, 0);
	endtask

	task automatic aluOp(input logic [2:0] r, input bit sub);
		logic [7:0] a;
		logic [7:0] b;
		a = modelReg[7];
		b = modelReg[r];
		if (sub)
		begin
			modelFlags.carry = (a < b);
			modelReg[7] = a - b;
		end
		else
		begin
			modelFlags.carry = (int'(a) + int'(b)) > 255;
			modelReg[7] = a + b;
		end
		modelFlags.zero = (modelReg[7] == 8'd0);
		modelFlags.subtract = sub;
		runInstr({3'b100, sub, 1'b0, r}, 8'h00, 1'b0, 0);
	endtask

	task automatic compareImm(input logic [7:0] imm);
		modelFlags.zero = (modelReg[7] == imm);
		modelFlags.subtract = 1'b1;
		modelFlags.carry = (modelReg[7] < imm);
		runInstr(OpCpN, imm, 1'b1, 0);
	endtask

	// Taken jumps add the signed offset to the pc after the offset byte
	task automatic jumpRel(input logic [7:0] op, input logic [7:0] off);
		bit taken;
		taken = (op == OpJr) || (op == OpJrZ && modelFlags.zero)
			|| (op == OpJrNz && !modelFlags.zero);
		runInstr(op, off, 1'b1, taken ? int'($signed(off)) : 0);
	endtask

	task automatic finishTest(input string name, input int startErrors);
		testsRun++;
		if (errorCount == startErrors)
			$display("%s: passed", name);
		else
		begin
			testsFailed++;
			$display("%s: %0d mismatches", name, errorCount - startErrors);
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////
	task automatic loadAllRegisters();
		int startErrors;
		startErrors = errorCount;
		for (int r = 0; r < 8; r++)
			if (r != 6)
				loadReg(3'(r), 8'(60 + 17 * r));
		runInstr(OpNop, 8'h00, 1'b0, 0);
		finishTest("load immediate", startErrors);
	endtask

	task automatic incDecWrap();
		int startErrors;
		startErrors = errorCount;
		// SUB 0 - 1 leaves carry set
		loadReg(3'd7, 8'h00);
		loadReg(3'd1, 8'h01);
		aluOp(3'd1, 1'b1);
		for (int r = 0; r < 8; r++)
		begin
			if (r != 6)
			begin
				loadReg(3'(r), 8'hFF);
				stepReg(3'(r), 1'b0);
				stepReg(3'(r), 1'b1);
			end
		end
		finishTest("inc dec", startErrors);
	endtask

	task automatic aluRandomPairs();
		int startErrors;
		logic [2:0] r;
		startErrors = errorCount;
		for (int i = 0; i < AluIters; i++)
		begin
			r = 3'($unsigned($random(seed)) % 8);
			if (r == 3'd6)
				r = 3'd7;
			loadReg(3'd7, 8'($random(seed)));
			loadReg(r, 8'($random(seed)));
			aluOp(r, i[0]);
		end
		finishTest("add sub", startErrors);
	endtask

	task automatic compareImmediate();
		int startErrors;
		startErrors = errorCount;
		loadReg(3'd7, 8'h55);
		compareImm(8'h55);
		compareImm(8'h10);
		compareImm(8'hA0);
		finishTest("compare", startErrors);
	endtask

	task automatic relativeJumps();
		int startErrors;
		startErrors = errorCount;
		jumpRel(OpJr, 8'h10);
		jumpRel(OpJr, 8'hE0);
		loadReg(3'd7, 8'h33);
		compareImm(8'h33);
		jumpRel(OpJrZ, 8'h04);
		jumpRel(OpJrNz, 8'h04);
		compareImm(8'h00);
		jumpRel(OpJrZ, 8'h06);
		jumpRel(OpJrNz, 8'hF8);
		finishTest("relative jumps", startErrors);
	endtask

	task automatic unknownOpcodes();
		int startErrors;
		logic [7:0] oddOps [10] = '{8'h34, 8'h35, 8'h36, 8'h86, 8'h96, 8'h76, 8'h10,
			8'hCB, 8'hC3, 8'hFF};
		startErrors = errorCount;
		heavyStall = 1'b1;
		for (int i = 0; i < 10; i++)
			runInstr(oddOps[i], 8'h00, 1'b0, 0);
		heavyStall = 1'b0;
		finishTest("unknown opcodes", startErrors);
	endtask

	initial
	begin
		clock = 1'b0;
		rst = 1'b1;
		heavyStall = 1'b0;
		seed = 43;
		errorCount = 0;
		checkCount = 0;
		testsRun = 0;
		testsFailed = 0;
		modelPc = StartPc;
		modelFlags = '0;
		for (int i = 0; i < 8; i++)
			modelReg[i] = '0;
		repeat (16) @(negedge clock);
		rst = 1'b0;

		loadAllRegisters();
		incDecWrap();
		aluRandomPairs();
		compareImmediate();
		relativeJumps();
		unknownOpcodes();

		$display("Tests %0d, failed %0d, checks %0d, mismatches %0d",
			testsRun, testsFailed, checkCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TimeoutCycles * ClockPeriod);
		$display("Timeout: %0d instructions did not all retire within %0d cycles",
			InstrCount, TimeoutCycles);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/programMemory.sv ====
`default_nettype none
`timescale 1ns/100ps

module programMemory
(
	input wire logic clock,
	input wire logic rst,
	input wire logic heavyStall,
	input wire logic fetchReqValid,
	output logic fetchReqReady,
	input wire isaPkg::fetchReqT fetchReq,
	output logic fetchRspValid,
	output logic [isaPkg::WordWidth-1:0] fetchRsp
);
	logic [isaPkg::WordWidth-1:0] mem [0:65535];
	logic [isaPkg::AddrWidth-1:0] pendingAddr;
	logic pending;
	integer seed;
	int delay;
	int roll;

	initial
	begin
		seed = 43;
		pending = 1'b0;
		pendingAddr = '0;
		delay = 0;
		roll = 0;
		fetchReqReady = 1'b0;
		fetchRspValid = 1'b0;
		fetchRsp = '0;
		// Background pattern until a test writes its bytes
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i[15:8] ^ i[7:0]);
	end

	// Ready and response change on the falling edge only
	always @(negedge clock)
	begin
		fetchRspValid = 1'b0;
		roll = int'($unsigned($random(seed)) % 4);
		if (rst)
		begin
			pending = 1'b0;
			fetchReqReady = 1'b0;
		end
		else if (pending)
		begin
			fetchReqReady = 1'b0;
			delay = delay - 1;
			if (delay == 0)
			begin
				fetchRspValid = 1'b1;
				fetchRsp = mem[pendingAddr];
				pending = 1'b0;
			end
		end
		else
		begin
			// Heavy mode grants one cycle in four
			fetchReqReady = heavyStall ? (roll == 0) : (roll != 0);
			if (fetchReqValid && fetchReqReady)
			begin
				pending = 1'b1;
				pendingAddr = fetchReq.addr;
				delay = 1 + int'($unsigned($random(seed)) % 4);
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/gbCore.sv ====
`default_nettype none
`timescale 1ns/100ps

module gbCore
#(
	parameter logic [isaPkg::AddrWidth-1:0] ResetPc = '0
)
(
	input wire logic clock,
	input wire logic rst,
	output logic fetchReqValid,
	input wire logic fetchReqReady,
	output isaPkg::fetchReqT fetchReq,
	input wire logic fetchRspValid,
	input wire logic [isaPkg::WordWidth-1:0] fetchRsp,
	output logic retireValid,
	output isaPkg::retireT retire
);
	import isaPkg::*;
	import ucodePkg::*;

	uopT uop;
	ucodeAddrT romAddr;
	ucodeAddrT flowAddr;
	logic uopStep;
	logic [WordWidth-1:0] opcode;
	logic [AddrWidth-1:0] pc;
	regFileT regs;
	flagsT flags;

	ucodeSequencer ucodeSequencer_inst
	(
		.clock(clock),
		.rst(rst),
		.uop(uop),
		.flowAddr(flowAddr),
		.zeroFlag(flags.zero),
		.fetchRsp(fetchRsp),
		.romAddr(romAddr),
		.uopStep(uopStep),
		.fetchReqValid(fetchReqValid),
		.fetchReqReady(fetchReqReady),
		.fetchRspValid(fetchRspValid),
		.retireValid(retireValid),
		.opcode(opcode)
	);

	// Flow lookup straight off the fetched byte
	opcodeMap opcodeMap_inst
	(
		.opcode(fetchRsp),
		.flowAddr(flowAddr)
	);

	ucodeRom ucodeRom_inst
	(
		.addr(romAddr),
		.uop(uop)
	);

	dataPath
	#(
		.ResetPc(ResetPc)
	)
	dataPath_inst
	(
		.clock(clock),
		.rst(rst),
		.uop(uop),
		.uopStep(uopStep),
		.fetchRsp(fetchRsp),
		.pc(pc),
		.regs(regs),
		.flags(flags),
		.fetchAddr(fetchReq)
	);

	assign retire = '{opcode: opcode, pc: pc, regs: regs, flags: flags, reserved: '0};

endmodule

`default_nettype wire

// ==== logic/dataPath.sv ====
`default_nettype none
`timescale 1ns/100ps

module dataPath
#(
	parameter logic [isaPkg::AddrWidth-1:0] ResetPc = '0
)
(
	input wire logic clock,
	input wire logic rst,
	input wire ucodePkg::uopT uop,
	input wire logic uopStep,
	input wire logic [isaPkg::WordWidth-1:0] fetchRsp,
	output logic [isaPkg::AddrWidth-1:0] pc,
	output isaPkg::regFileT regs,
	output isaPkg::flagsT flags,
	output isaPkg::fetchReqT fetchAddr
);
	import isaPkg::*;
	import ucodePkg::*;

	logic [WordWidth-1:0] offset;
	logic [WordWidth-1:0] srcVal;
	logic [WordWidth-1:0] subRhs;
	logic [WordWidth-1:0] incVal;
	logic [WordWidth-1:0] decVal;
	logic [WordWidth:0] addSum;
	logic [WordWidth:0] subDiff;
	logic [AddrWidth-1:0] jumpTarget;
	logic pcInc;

	function automatic regFileT writeReg(regFileT rf, regIdE id, logic [WordWidth-1:0] value);
		regFileT res;
		res = rf;
		case (id)
			RegB: res.b = value;
			RegC: res.c = value;
			RegD: res.d = value;
			RegE: res.e = value;
			RegH: res.h = value;
			RegL: res.l = value;
			RegA: res.a = value;
			default: ;
		endcase
		return res;
	endfunction

	////////////////////
	// Operand select and ALU
	////////////////////
	always_comb
	begin
		case (uop.operand)
			RegB: srcVal = regs.b;
			RegC: srcVal = regs.c;
			RegD: srcVal = regs.d;
			RegE: srcVal = regs.e;
			RegH: srcVal = regs.h;
			RegL: srcVal = regs.l;
			default: srcVal = regs.a;
		endcase
	end

	assign incVal = srcVal + 1'b1;
	assign decVal = srcVal - 1'b1;
	assign addSum = {1'b0, regs.a} + {1'b0, srcVal};
	// CP compares against the immediate byte
	assign subRhs = (uop.action == ActCmpImm) ? fetchRsp : srcVal;
	assign subDiff = {1'b0, regs.a} - {1'b0, subRhs};

	assign pcInc = uop.next inside {NextInc, NextIncEof, NextIncEofZ, NextIncEofNz};
	assign jumpTarget = pc + {{(AddrWidth-WordWidth){offset[WordWidth-1]}}, offset};
	assign fetchAddr = '{addr: pc};

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			pc <= ResetPc;
			regs <= '0;
			flags <= '0;
		end
		else if (uopStep)
		begin
			if (uop.action == ActJumpRel)
				pc <= jumpTarget;
			else if (pcInc)
				pc <= pc + 1'b1;

			case (uop.action)
				ActLoadImm: regs <= writeReg(regs, uop.operand, fetchRsp);
				ActIncReg:
				begin
					regs <= writeReg(regs, uop.operand, incVal);
					flags.zero <= (incVal == '0);
					flags.subtract <= 1'b0;
				end
				ActDecReg:
				begin
					regs <= writeReg(regs, uop.operand, decVal);
					flags.zero <= (decVal == '0);
					flags.subtract <= 1'b1;
				end
				ActAddA:
				begin
					regs.a <= addSum[WordWidth-1:0];
					flags <= '{zero: (addSum[WordWidth-1:0] == '0), subtract: 1'b0,
						carry: addSum[WordWidth]};
				end
				ActSubA, ActCmpImm:
				begin
					if (uop.action == ActSubA)
						regs.a <= subDiff[WordWidth-1:0];
					// Borrow shows up in the top bit
					flags <= '{zero: (subDiff[WordWidth-1:0] == '0), subtract: 1'b1,
						carry: subDiff[WordWidth]};
				end
				default: ;
			endcase
		end
	end

	// Jump offset latched from the program
	always_ff @(posedge clock)
	begin
		if (uopStep && uop.action == ActLoadOffset)
			offset <= fetchRsp;
	end

endmodule

`default_nettype wire

// ==== logic/ucodeSequencer.sv ====
`default_nettype none
`timescale 1ns/100ps

module ucodeSequencer
(
	input wire logic clock,
	input wire logic rst,
	input wire ucodePkg::uopT uop,
	input wire ucodePkg::ucodeAddrT flowAddr,
	input wire logic zeroFlag,
	input wire logic [isaPkg::WordWidth-1:0] fetchRsp,
	output ucodePkg::ucodeAddrT romAddr,
	output logic uopStep,
	output logic fetchReqValid,
	input wire logic fetchReqReady,
	input wire logic fetchRspValid,
	output logic retireValid,
	output logic [isaPkg::WordWidth-1:0] opcode
);
	import ucodePkg::*;

	seqStateE state;
	ucodeAddrT upc;
	logic needsFetch;
	logic issuing;
	logic endFlow;

	assign romAddr = upc;
	assign needsFetch = actionFetches(uop.action);

	// Retire cycle also issues the next opcode fetch
	assign issuing = (state == SeqIssue) || (state == SeqRetire);
	assign fetchReqValid = issuing && needsFetch;
	assign uopStep = (issuing && !needsFetch) || (state == SeqWaitRsp && fetchRspValid);
	assign retireValid = (state == SeqRetire);

	// Conditional flow exit
	always_comb
	begin
		case (uop.next)
			NextEof, NextIncEof: endFlow = 1'b1;
			NextIncEofZ: endFlow = zeroFlag;
			NextIncEofNz: endFlow = !zeroFlag;
			default: endFlow = 1'b0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= SeqIssue;
			upc <= FlowFetch;
		end
		else if (uopStep)
		begin
			if (uop.action == ActFetchOpcode)
			begin
				upc <= flowAddr;
				state <= SeqIssue;
			end
			else if (endFlow)
			begin
				upc <= FlowFetch;
				state <= SeqRetire;
			end
			else
			begin
				upc <= upc + ucodeAddrT'(1);
				state <= SeqIssue;
			end
		end
		else if (fetchReqValid && fetchReqReady)
			state <= SeqWaitRsp;
		else if (state == SeqRetire)
			state <= SeqIssue;
	end

	// Opcode kept for the retire record
	always_ff @(posedge clock)
	begin
		if (uopStep && uop.action == ActFetchOpcode)
			opcode <= fetchRsp;
	end

endmodule

`default_nettype wire

// ==== logic/ucodeRom.sv ====
`default_nettype none
`timescale 1ns/100ps

module ucodeRom
(
	input wire ucodePkg::ucodeAddrT addr,
	output ucodePkg::uopT uop
);
	import isaPkg::*;
	import ucodePkg::*;

	ucodeAddrT flowBase;
	regIdE famReg;

	// Family flows are indexed by the register code
	assign flowBase = {addr[5:3], 3'b000};
	assign famReg = regIdE'(addr[2:0]);

	always_comb
	begin
		// Unused slots end quietly
		uop = '{next: NextEof, action: ActNop, operand: RegB};

		case (addr)
			////////////////////
			// Opcode fetch
			////////////////////
			FlowFetch: uop = '{next: NextInc, action: ActFetchOpcode, operand: RegB};

			FlowNop: uop = '{next: NextEof, action: ActNop, operand: RegB};

			////////////////////
			// Relative jumps
			////////////////////
			FlowJr: uop = '{next: NextInc, action: ActLoadOffset, operand: RegB};
			FlowJr + 6'd1: uop = '{next: NextEof, action: ActJumpRel, operand: RegB};

			// Not taken when Z is clear
			FlowJrZ: uop = '{next: NextIncEofNz, action: ActLoadOffset, operand: RegB};
			FlowJrZ + 6'd1: uop = '{next: NextEof, action: ActJumpRel, operand: RegB};

			// Not taken when Z is set
			FlowJrNz: uop = '{next: NextIncEofZ, action: ActLoadOffset, operand: RegB};
			FlowJrNz + 6'd1: uop = '{next: NextEof, action: ActJumpRel, operand: RegB};

			FlowCp: uop = '{next: NextIncEof, action: ActCmpImm, operand: RegB};

			default:
			begin
				// Slot 6 of a family is the (HL) form
				if (addr[2:0] != 3'd6)
				begin
					case (flowBase)
						FlowLd:
							uop = '{next: NextIncEof, action: ActLoadImm, operand: famReg};
						FlowInc:
							uop = '{next: NextEof, action: ActIncReg, operand: famReg};
						FlowDec:
							uop = '{next: NextEof, action: ActDecReg, operand: famReg};
						FlowAdd:
							uop = '{next: NextEof, action: ActAddA, operand: famReg};
						FlowSub:
							uop = '{next: NextEof, action: ActSubA, operand: famReg};
						default: ;
					endcase
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/opcodeMap.sv ====
`default_nettype none
`timescale 1ns/100ps

module opcodeMap
(
	input wire logic [isaPkg::WordWidth-1:0] opcode,
	output ucodePkg::ucodeAddrT flowAddr
);
	import isaPkg::*;
	import ucodePkg::*;

	logic [2:0] dstField;
	logic [2:0] srcField;

	// Destination field for LD, INC, DEC and source field for ALU ops
	assign dstField = opcode[5:3];
	assign srcField = opcode[2:0];

	always_comb
	begin
		flowAddr = FlowNop;

		// 00 rrr 1xx family with the (HL) forms left on NOP
		if (opcode[7:6] == 2'b00 && dstField != 3'd6)
		begin
			case (srcField)
				3'd4: flowAddr = FlowInc + {3'b000, dstField};
				3'd5: flowAddr = FlowDec + {3'b000, dstField};
				3'd6: flowAddr = FlowLd + {3'b000, dstField};
				default: flowAddr = FlowNop;
			endcase
		end

		// ADD A,r is 10000rrr and SUB r is 10010rrr
		if (opcode[7:3] == 5'b10000 && srcField != 3'd6)
			flowAddr = FlowAdd + {3'b000, srcField};
		if (opcode[7:3] == 5'b10010 && srcField != 3'd6)
			flowAddr = FlowSub + {3'b000, srcField};

		case (opcode)
			OpNop: flowAddr = FlowNop;
			OpJr: flowAddr = FlowJr;
			OpJrZ: flowAddr = FlowJrZ;
			OpJrNz: flowAddr = FlowJrNz;
			OpCpN: flowAddr = FlowCp;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/ucodePkg.sv ====
`default_nettype none

package ucodePkg;

	// How the flow continues after a micro-op
	typedef enum logic [2:0]
	{
		NextOp,
		NextEof,
		NextIncEof,
		NextIncEofZ,
		NextIncEofNz,
		NextInc
	} uopNextE;

	typedef enum logic [3:0]
	{
		ActNop,
		ActFetchOpcode,
		ActLoadImm,
		ActIncReg,
		ActDecReg,
		ActAddA,
		ActSubA,
		ActCmpImm,
		ActLoadOffset,
		ActJumpRel
	} uopActionE;

	typedef struct packed
	{
		uopNextE next;
		uopActionE action;
		isaPkg::regIdE operand;
	} uopT;

	typedef logic [5:0] ucodeAddrT;

	////////////////////
	// Flow start addresses
	////////////////////
	localparam ucodeAddrT FlowFetch = 6'd0;
	localparam ucodeAddrT FlowNop   = 6'd1;
	localparam ucodeAddrT FlowJr    = 6'd2;
	localparam ucodeAddrT FlowJrZ   = 6'd4;
	localparam ucodeAddrT FlowJrNz  = 6'd6;
	localparam ucodeAddrT FlowCp    = 6'd8;
	// Register families with eight slots each
	localparam ucodeAddrT FlowLd    = 6'd16;
	localparam ucodeAddrT FlowInc   = 6'd24;
	localparam ucodeAddrT FlowDec   = 6'd32;
	localparam ucodeAddrT FlowAdd   = 6'd40;
	localparam ucodeAddrT FlowSub   = 6'd48;

	typedef enum logic [1:0]
	{
		SeqIssue,
		SeqWaitRsp,
		SeqRetire
	} seqStateE;

	// Actions that consume one program byte
	function automatic logic actionFetches(uopActionE action);
		return action inside {ActFetchOpcode, ActLoadImm, ActCmpImm, ActLoadOffset};
	endfunction

endpackage

`default_nettype wire

// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

	parameter int WordWidth = 8;
	parameter int AddrWidth = 16;

	// Operand field encoding where code 6 is the (HL) form
	typedef enum logic [2:0]
	{
		RegB = 3'd0,
		RegC = 3'd1,
		RegD = 3'd2,
		RegE = 3'd3,
		RegH = 3'd4,
		RegL = 3'd5,
		RegA = 3'd7
	} regIdE;

	// Opcodes with a flow of their own
	typedef enum logic [7:0]
	{
		OpNop  = 8'h00,
		OpJr   = 8'h18,
		OpJrNz = 8'h20,
		OpJrZ  = 8'h28,
		OpCpN  = 8'hFE
	} opcodeE;

	typedef struct packed
	{
		logic zero;
		logic subtract;
		logic carry;
	} flagsT;

	typedef struct packed
	{
		logic [WordWidth-1:0] b;
		logic [WordWidth-1:0] c;
		logic [WordWidth-1:0] d;
		logic [WordWidth-1:0] e;
		logic [WordWidth-1:0] h;
		logic [WordWidth-1:0] l;
		logic [WordWidth-1:0] a;
	} regFileT;

	// Architectural state after one instruction
	typedef struct packed
	{
		logic [WordWidth-1:0] opcode;
		logic [AddrWidth-1:0] pc;
		regFileT regs;
		flagsT flags;
		logic [12:0] reserved;
	} retireT;

	typedef struct packed
	{
		logic [AddrWidth-1:0] addr;
	} fetchReqT;

endpackage

`default_nettype wire
